/* hdl/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

    // Result write port of the datapath.
    localparam int DATA_WIDTH  = 16;
    localparam int WADDR_WIDTH = 10;

    typedef logic [DATA_WIDTH-1:0]  word_t;
    typedef logic [WADDR_WIDTH-1:0] waddr_t;

    // Instruction memory, one word per PC value.
    localparam int PC_WIDTH    = 8;
    localparam int I_DEPTH     = 2 ** PC_WIDTH;
    localparam int INSTR_WIDTH = 16;

    typedef logic [PC_WIDTH-1:0]    pc_t;
    typedef logic [INSTR_WIDTH-1:0] instr_t;

    localparam int THREAD_COUNT = 4;
    localparam int THREAD_WIDTH = 2;

    typedef logic [THREAD_WIDTH-1:0] thread_t;

    // Folded branch entries.
    localparam int BRANCH_COUNT     = 4;
    localparam int BRANCH_IDX_WIDTH = 2;
    localparam int BRANCH_STRIDE    = 4;    // Address slots per entry.

    typedef logic [BRANCH_IDX_WIDTH-1:0] branch_idx_t;

    // Address map of the result write port.
    localparam waddr_t I_WRITE_BASE      = 10'h100;
    localparam waddr_t BRANCH_WRITE_BASE = 10'h200;

    typedef enum logic [1:0] {
        FIELD_ORIGIN = 2'd0,
        FIELD_DEST   = 2'd1,
        FIELD_COND   = 2'd2
    } field_e;

    // Tested on the result word of the current cycle.
    typedef enum logic [1:0] {
        COND_NEVER   = 2'd0,
        COND_ALWAYS  = 2'd1,
        COND_ZERO    = 2'd2,
        COND_NONZERO = 2'd3
    } cond_e;

    // Pipeline depths.
    localparam int I_TAP_DEPTH   = 2;
    localparam int READY_DEPTH   = 1;
    localparam int FETCH_LATENCY = I_TAP_DEPTH + 1;    // RAM read register plus taps.

endpackage

`default_nettype wire

/* hdl/delay_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module delay_pipe #(
    parameter type      payload_t   = logic,
    parameter int       DEPTH       = 1,
    parameter payload_t RESET_VALUE = payload_t'(0)
) (
    input  wire           clock,
    input  wire           rst,
    input  wire payload_t in,
    output payload_t      out
);

    payload_t stages [DEPTH];    // stages[0] takes the input.

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stages[i] <= RESET_VALUE;
            end
        end else begin
            stages[0] <= in;
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign out = stages[DEPTH-1];

    // A zero-depth pipe would leave out undriven.
    a_depth_min: assert property (@(posedge clock) DEPTH >= 1);

endmodule

`default_nettype wire

/* hdl/instr_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_mem (
    input  wire                   clock,
    input  wire                   rst,
    input  wire                   write_en,
    input  wire ctrl_pkg::waddr_t write_addr,
    input  wire ctrl_pkg::word_t  write_data,
    input  wire ctrl_pkg::pc_t    pc,
    output ctrl_pkg::instr_t      instr
);

    import ctrl_pkg::*;

    instr_t mem [I_DEPTH];
    instr_t read_word;    // Registered RAM output.
    logic   i_wren;

    // Upper address bits select the instruction window, low bits the word.
    assign i_wren = write_en &&
        (write_addr[WADDR_WIDTH-1:PC_WIDTH] == I_WRITE_BASE[WADDR_WIDTH-1:PC_WIDTH]);

    always_ff @(posedge clock) begin
        if (i_wren) begin
            mem[write_addr[PC_WIDTH-1:0]] <= instr_t'(write_data);
        end
    end

    // Read port, old data on a same-address write.
    always_ff @(posedge clock) begin
        if (rst) begin
            read_word <= '0;    // Keeps instr at zero until the first real fetch.
        end else begin
            read_word <= mem[pc];
        end
    end

    // Tap stages sit directly after the RAM so they can retime into it.
    // Nothing may tap the word before them.
    delay_pipe #(
        .payload_t   (instr_t),
        .DEPTH       (I_TAP_DEPTH),
        .RESET_VALUE (instr_t'(0))
    ) i_tap_pipe (
        .clock (clock),
        .rst   (rst),
        .in    (read_word),
        .out   (instr)
    );

endmodule

`default_nettype wire

/* hdl/branch_config.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_config (
    input  wire                   clock,
    input  wire                   rst,
    input  wire                   write_en,
    input  wire ctrl_pkg::waddr_t write_addr,
    input  wire ctrl_pkg::word_t  write_data,
    output logic [ctrl_pkg::BRANCH_COUNT-1:0] cfg_we,
    output ctrl_pkg::field_e      cfg_field,
    output ctrl_pkg::word_t       cfg_value
);

    import ctrl_pkg::*;

    localparam int BRANCH_SPAN = BRANCH_COUNT * BRANCH_STRIDE;

    waddr_t      offset;
    branch_idx_t entry;
    logic [1:0]  field_bits;
    logic        in_window;

    assign offset = write_addr - BRANCH_WRITE_BASE;

    // Addresses below the base wrap to large offsets and fall out here too.
    assign in_window  = (offset < waddr_t'(BRANCH_SPAN));
    assign entry      = offset[BRANCH_IDX_WIDTH+1:2];
    assign field_bits = offset[1:0];

    always_comb begin
        cfg_we = '0;
        if (write_en && in_window && (field_bits != 2'd3)) begin    // Slot 3 is unused.
            cfg_we[entry] = 1'b1;
        end
    end

    assign cfg_field = field_e'(field_bits);
    assign cfg_value = write_data;    // Every entry sees the same value.

    // At most one entry may take a given write.
    a_we_onehot: assert property (
        @(posedge clock) disable iff (rst)
        $onehot0(cfg_we)
    );

endmodule

`default_nettype wire

/* hdl/branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  wire                   clock,
    input  wire                   rst,
    input  wire                   cfg_we,
    input  wire ctrl_pkg::field_e cfg_field,
    input  wire ctrl_pkg::word_t  cfg_value,
    input  wire ctrl_pkg::pc_t    pc,
    input  wire ctrl_pkg::word_t  result,
    output logic                  match,
    output ctrl_pkg::pc_t         dest
);

    import ctrl_pkg::*;

    pc_t   origin;
    pc_t   destination;
    cond_e condition;
    logic  cond_ok;

    always_ff @(posedge clock) begin
        if (cfg_we && (cfg_field == FIELD_ORIGIN)) begin
            origin <= pc_t'(cfg_value);
        end
        if (cfg_we && (cfg_field == FIELD_DEST)) begin
            destination <= pc_t'(cfg_value);
        end
    end

    // The entry comes out of reset idle.
    always_ff @(posedge clock) begin
        if (rst) begin
            condition <= COND_NEVER;
        end else if (cfg_we && (cfg_field == FIELD_COND)) begin
            condition <= cond_e'(cfg_value[1:0]);
        end
    end

    always_comb begin
        case (condition)
            COND_ALWAYS:  cond_ok = 1'b1;
            COND_ZERO:    cond_ok = (result == '0);
            COND_NONZERO: cond_ok = (result != '0);
            default:      cond_ok = 1'b0;    // COND_NEVER.
        endcase
    end

    assign match = (pc == origin) && cond_ok;
    assign dest  = destination;

endmodule

`default_nettype wire

/* hdl/branch_select.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_select (
    input  wire [ctrl_pkg::BRANCH_COUNT-1:0] match,
    input  wire ctrl_pkg::pc_t               dest [ctrl_pkg::BRANCH_COUNT],
    output logic                             jump,
    output ctrl_pkg::pc_t                    jump_dest
);

    import ctrl_pkg::*;

    assign jump = |match;

    // Scan from the top down so the lowest matching index is left standing.
    always_comb begin
        jump_dest = '0;
        for (int i = BRANCH_COUNT - 1; i >= 0; i--) begin
            if (match[i]) begin
                jump_dest = dest[i];
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/pc_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_controller (
    input  wire                clock,
    input  wire                rst,
    input  wire                jump,
    input  wire ctrl_pkg::pc_t jump_dest,
    input  wire                ready,
    output ctrl_pkg::pc_t      pc,
    output ctrl_pkg::thread_t  thread
);

    import ctrl_pkg::*;

    pc_t     pc_mem [THREAD_COUNT];    // Stored PC of each thread.
    thread_t thread_next;
    pc_t     pc_next;

    assign thread_next = thread_t'(thread + 1'b1);    // Wraps at THREAD_COUNT.

    // Hold wins over a taken branch, a branch over fall-through.
    always_comb begin
        if (!ready) begin
            pc_next = pc;
        end else if (jump) begin
            pc_next = jump_dest;
        end else begin
            pc_next = pc_t'(pc + 1'b1);
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            thread <= '0;
            pc     <= '0;
            for (int i = 0; i < THREAD_COUNT; i++) begin
                pc_mem[i] <= '0;
            end
        end else begin
            pc_mem[thread] <= pc_next;
            thread         <= thread_next;
            pc             <= pc_mem[thread_next];    // Next thread was last written 3 turns ago.
        end
    end

    // Strict round-robin once out of reset.
    a_thread_step: assert property (
        @(posedge clock) disable iff (rst)
        !$past(rst) |-> (thread == thread_t'($past(thread) + 1'b1))
    );

endmodule

`default_nettype wire

/* hdl/control_path.sv */
`timescale 1ns/1ps
`default_nettype none

module control_path (
    input  wire                   clock,
    input  wire                   rst,
    input  wire                   write_en,
    input  wire ctrl_pkg::waddr_t write_addr,
    input  wire ctrl_pkg::word_t  write_data,
    input  wire                   io_ready,
    output ctrl_pkg::pc_t         pc,
    output ctrl_pkg::thread_t     thread,
    output ctrl_pkg::instr_t      instr
);

    import ctrl_pkg::*;

    wire [BRANCH_COUNT-1:0] cfg_we;
    wire field_e            cfg_field;
    wire word_t             cfg_value;
    wire [BRANCH_COUNT-1:0] branch_match;
    wire pc_t               branch_dest [BRANCH_COUNT];
    wire                    jump;
    wire pc_t               jump_dest;
    wire                    ready_ctrl;

    instr_mem i_mem (
        .clock      (clock),
        .rst        (rst),
        .write_en   (write_en),
        .write_addr (write_addr),
        .write_data (write_data),
        .pc         (pc),
        .instr      (instr)
    );

    branch_config b_cfg (
        .clock      (clock),
        .rst        (rst),
        .write_en   (write_en),
        .write_addr (write_addr),
        .write_data (write_data),
        .cfg_we     (cfg_we),
        .cfg_field  (cfg_field),
        .cfg_value  (cfg_value)
    );

    // The condition sees the result being written this cycle.
    for (genvar i = 0; i < BRANCH_COUNT; i++) begin : g_branch
        branch_unit b_unit (
            .clock     (clock),
            .rst       (rst),
            .cfg_we    (cfg_we[i]),
            .cfg_field (cfg_field),
            .cfg_value (cfg_value),
            .pc        (pc),
            .result    (write_data),
            .match     (branch_match[i]),
            .dest      (branch_dest[i])
        );
    end

    branch_select b_sel (
        .match     (branch_match),
        .dest      (branch_dest),
        .jump      (jump),
        .jump_dest (jump_dest)
    );

    // Lines io_ready up with the operand reads.
    delay_pipe #(
        .payload_t   (logic),
        .DEPTH       (READY_DEPTH),
        .RESET_VALUE (1'b1)
    ) ready_pipe (
        .clock (clock),
        .rst   (rst),
        .in    (io_ready),
        .out   (ready_ctrl)
    );

    pc_controller ctrl (
        .clock     (clock),
        .rst       (rst),
        .jump      (jump),
        .jump_dest (jump_dest),
        .ready     (ready_ctrl),
        .pc        (pc),
        .thread    (thread)
    );

endmodule

`default_nettype wire

/* verif/control_path_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module control_path_tb;

    import ctrl_pkg::*;

    localparam int RESET_CYCLES = 5;
    localparam int TEST_CYCLES  = (RESET_CYCLES - 1) + 20 + (256 + 40) + (RESET_CYCLES + 3 + 40)
        + (RESET_CYCLES + 12 + 64) + (RESET_CYCLES + 40) + (RESET_CYCLES + 24 + 40);
    localparam int CYCLE_LIMIT  = TEST_CYCLES + TEST_CYCLES / 5;    // 20 percent margin.

    logic    clock = 1'b0;
    logic    rst;
    logic    write_en;
    waddr_t  write_addr;
    word_t   write_data;
    logic    io_ready;
    pc_t     pc;
    thread_t thread;
    instr_t  instr;

    // Reference model.
    instr_t  m_mem [I_DEPTH];
    logic    m_mem_ok [I_DEPTH];             // Word has been written.
    instr_t  m_pipe [FETCH_LATENCY];         // Fetches in flight, last one is on instr.
    logic    m_pipe_ok [FETCH_LATENCY];
    pc_t     m_origin [BRANCH_COUNT];
    pc_t     m_dest [BRANCH_COUNT];
    cond_e   m_cond [BRANCH_COUNT];
    pc_t     m_pcs [THREAD_COUNT];
    thread_t m_thread;
    logic    m_ready;                        // Delayed io_ready.
    logic    m_pending [THREAD_COUNT];       // Branch taken, checked on the next turn.
    pc_t     m_pend_dest [THREAD_COUNT];

    logic [31:0] lfsr_state;
    int          cycle_count = 0;
    int          jump_count  = 0;

    control_path uut (
        .clock      (clock),
        .rst        (rst),
        .write_en   (write_en),
        .write_addr (write_addr),
        .write_data (write_data),
        .io_ready   (io_ready),
        .pc         (pc),
        .thread     (thread),
        .instr      (instr)
    );

    always #10 clock = ~clock;

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            stop_run($sformatf("Timeout: the run passed %0d cycles without finishing.",
                               CYCLE_LIMIT));
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};    // Taps 32, 22, 2, 1.
    endfunction

    function automatic word_t random_bits(input int n);
        word_t w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);    // One step per bit.
            w = {w[DATA_WIDTH-2:0], lfsr_state[0]};
        end
        return w;
    endfunction

    function automatic logic cond_holds(input cond_e c, input word_t r);
        case (c)
            COND_ALWAYS:  return 1'b1;
            COND_ZERO:    return r == '0;
            COND_NONZERO: return r != '0;
            default:      return 1'b0;
        endcase
    endfunction

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic fail_value(input string msg);
        stop_run($sformatf("Fail at %0t ns: %s", $time, msg));
    endtask

    task automatic check_pc(input pc_t exp_pc, input thread_t exp_thread);
        if (thread !== exp_thread) begin
            fail_value($sformatf("thread is %0d, expected %0d", thread, exp_thread));
        end else if (pc !== exp_pc) begin
            fail_value($sformatf("thread %0d pc is %0d, expected %0d", thread, pc, exp_pc));
        end
    endtask

    task automatic check_instr(input instr_t exp_instr);
        if (instr !== exp_instr) begin
            fail_value($sformatf("instr is %h, expected %h", instr, exp_instr));
        end
    endtask

    task automatic check_jump_path(input pc_t exp_dest);
        if (pc !== exp_dest) begin
            fail_value($sformatf("thread %0d pc after branch is %0d, expected %0d",
                                 thread, pc, exp_dest));
        end
    endtask

    task automatic reset_model();
        m_thread = '0;
        m_ready  = 1'b1;
        for (int t = 0; t < THREAD_COUNT; t++) begin
            m_pcs[t]     = '0;
            m_pending[t] = 1'b0;
        end
        for (int e = 0; e < BRANCH_COUNT; e++) begin
            m_cond[e] = COND_NEVER;
        end
        for (int s = 0; s < FETCH_LATENCY; s++) begin
            m_pipe[s]    = '0;
            m_pipe_ok[s] = 1'b1;
        end
    endtask

    // Models the edge with the inputs just sampled, then drives the next ones and checks.
    task automatic run_cycle(input logic r, input logic we, input waddr_t a, input word_t d,
                             input logic rdy);
        pc_t  cur_pc;
        pc_t  next_pc;
        pc_t  target;
        logic taken;
        int   rel;
        @(posedge clock);
        if (rst) begin
            reset_model();
        end else begin
            cur_pc = m_pcs[m_thread];
            taken  = 1'b0;
            target = '0;
            for (int e = 0; e < BRANCH_COUNT; e++) begin    // Lowest entry first.
                if (!taken && m_origin[e] == cur_pc && cond_holds(m_cond[e], write_data)) begin
                    taken  = 1'b1;
                    target = m_dest[e];
                end
            end
            if (!m_ready) begin
                next_pc = cur_pc;    // Re-issue on the next turn.
            end else if (taken) begin
                next_pc               = target;
                m_pending[m_thread]   = 1'b1;
                m_pend_dest[m_thread] = target;
            end else begin
                next_pc = cur_pc + 1'b1;
            end
            for (int s = FETCH_LATENCY - 1; s > 0; s--) begin
                m_pipe[s]    = m_pipe[s-1];
                m_pipe_ok[s] = m_pipe_ok[s-1];
            end
            m_pipe[0]    = m_mem[cur_pc];    // Old word if written at this edge.
            m_pipe_ok[0] = m_mem_ok[cur_pc];
            rel = int'(write_addr) - int'(BRANCH_WRITE_BASE);
            if (write_en && write_addr >= I_WRITE_BASE && write_addr < BRANCH_WRITE_BASE) begin
                m_mem[write_addr[7:0]]    = instr_t'(write_data);
                m_mem_ok[write_addr[7:0]] = 1'b1;
            end else if (write_en && rel >= 0 && rel < 4 * BRANCH_COUNT) begin
                case (rel % 4)
                    0: m_origin[rel / 4] = pc_t'(write_data);
                    1: m_dest[rel / 4]   = pc_t'(write_data);
                    2: m_cond[rel / 4]   = cond_e'(write_data[1:0]);
                    default: ;    // Unused slot.
                endcase
            end
            m_pcs[m_thread] = next_pc;
            m_thread        = m_thread + 1'b1;
            m_ready         = io_ready;
        end
        #2;
        rst        = r;
        write_en   = we;
        write_addr = a;
        write_data = d;
        io_ready   = rdy;
        if (m_pending[m_thread]) begin
            check_jump_path(m_pend_dest[m_thread]);
            m_pending[m_thread] = 1'b0;
            jump_count          = jump_count + 1;
        end
        check_pc(m_pcs[m_thread], m_thread);
        if (m_pipe_ok[FETCH_LATENCY-1]) begin
            check_instr(m_pipe[FETCH_LATENCY-1]);
        end
    endtask

    task automatic apply_reset();
        repeat (RESET_CYCLES) run_cycle(1'b1, 1'b0, '0, '0, 1'b1);
        jump_count = 0;
    endtask

    task automatic write_word(input waddr_t a, input word_t d);
        run_cycle(1'b0, 1'b1, a, d, 1'b1);
    endtask

    task automatic program_branch(input branch_idx_t idx, input pc_t origin, input pc_t dest,
                                  input cond_e cond);
        waddr_t base;
        base = BRANCH_WRITE_BASE + waddr_t'(BRANCH_STRIDE * idx);
        write_word(base + 10'd0, word_t'(origin));
        write_word(base + 10'd1, word_t'(dest));
        write_word(base + 10'd2, word_t'(cond));    // Enabled last.
    endtask

    task automatic test_round_robin();
        repeat (20) run_cycle(1'b0, 1'b0, '0, '0, 1'b1);
    endtask

    task automatic test_instr_fetch();
        for (int i = 0; i < I_DEPTH; i++) begin
            write_word(I_WRITE_BASE + waddr_t'(i), random_bits(INSTR_WIDTH));
        end
        repeat (40) run_cycle(1'b0, 1'b0, '0, '0, 1'b1);
    endtask

    task automatic test_branch_always();
        apply_reset();
        program_branch(2'd0, 8'd5, 8'd40, COND_ALWAYS);
        repeat (40) run_cycle(1'b0, 1'b0, '0, '0, 1'b1);
        if (jump_count < THREAD_COUNT) begin
            stop_run($sformatf("Only %0d threads took the branch at pc 5.", jump_count));
        end
    endtask

    task automatic test_branch_cond();
        word_t result;
        apply_reset();
        program_branch(2'd1, 8'd12, 8'd30, COND_ZERO);
        program_branch(2'd2, 8'd12, 8'd60, COND_NONZERO);
        program_branch(2'd3, 8'd12, 8'd90, COND_ALWAYS);     // Always loses to 1 or 2.
        program_branch(2'd0, 8'd30, 8'd100, COND_NONZERO);   // Zero falls through to 31.
        for (int i = 0; i < 64; i++) begin
            if (random_bits(1) == 1) begin
                result = '0;
            end else begin
                result = random_bits(DATA_WIDTH);
                if (result == '0) begin
                    result = 16'd1;
                end
            end
            run_cycle(1'b0, 1'b0, '0, result, 1'b1);
        end
        if (jump_count < THREAD_COUNT) begin
            stop_run($sformatf("Only %0d branches were taken at pc 12 and 30.", jump_count));
        end
    endtask

    task automatic test_ready_hold();
        apply_reset();
        for (int i = 0; i < 40; i++) begin
            run_cycle(1'b0, 1'b0, '0, '0, (i % 5) != 2);    // Low in every fifth cycle.
        end
    endtask

    task automatic test_ignored_writes();
        waddr_t ignored [12] = '{10'h203, 10'h207, 10'h20B, 10'h20F, 10'h210, 10'h212,
                                 10'h2FE, 10'h000, 10'h080, 10'h0FF, 10'h300, 10'h3FF};
        apply_reset();
        for (int e = 0; e < BRANCH_COUNT; e++) begin    // Origins on every thread's path.
            program_branch(branch_idx_t'(e), pc_t'(8 + e), 8'd70, COND_NEVER);
        end
        foreach (ignored[i]) begin
            write_word(ignored[i], 16'h0009);    // Reads as COND_ALWAYS and as pc 9.
        end
        repeat (40) run_cycle(1'b0, 1'b0, '0, random_bits(DATA_WIDTH), 1'b1);
    endtask

    initial begin
        rst        = 1'b1;
        write_en   = 1'b0;
        write_addr = '0;
        write_data = '0;
        io_ready   = 1'b1;
        lfsr_state = 32'h004f_6212;
        for (int i = 0; i < I_DEPTH; i++) begin
            m_mem_ok[i] = 1'b0;    // RAM has no reset.
        end
        repeat (RESET_CYCLES - 1) run_cycle(1'b1, 1'b0, '0, '0, 1'b1);
        test_round_robin();
        test_instr_fetch();
        test_branch_always();
        test_branch_cond();
        test_ready_hold();
        test_ignored_writes();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
hdl/ctrl_pkg.sv
hdl/delay_pipe.sv
hdl/instr_mem.sv
hdl/branch_config.sv
hdl/branch_unit.sv
hdl/branch_select.sv
hdl/pc_controller.sv
hdl/control_path.sv
verif/control_path_tb.sv

/* Bender.yml */
package:
  name: control_path

sources:
  - hdl/ctrl_pkg.sv
  - hdl/delay_pipe.sv
  - hdl/instr_mem.sv
  - hdl/branch_config.sv
  - hdl/branch_unit.sv
  - hdl/branch_select.sv
  - hdl/pc_controller.sv
  - hdl/control_path.sv
  - target: test
    files:
      - verif/control_path_tb.sv
